// ==== build.f ====
design/dcx_ctrl_pkg.sv
design/hold_timer.sv
design/reset_sequencer.sv
design/status_led.sv
design/lockloss_monitor.sv
design/dcx_control_top.sv
tb/dcx_control_props.sv
tb/tb_dcx_control.sv

// ==== Bender.yml ====
package:
  name: dcx_control

sources:
  - files:
      - design/dcx_ctrl_pkg.sv
      - design/hold_timer.sv
      - design/reset_sequencer.sv
      - design/status_led.sv
      - design/lockloss_monitor.sv
      - design/dcx_control_top.sv
  - target: test
    files:
      - tb/dcx_control_props.sv
      - tb/tb_dcx_control.sv

// ==== tb/tb_dcx_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcx_control
    import dcx_ctrl_pkg::*;
();

    localparam int unsigned SEED            = 6;
    localparam int unsigned GAP_MAX         = 20;
    localparam int unsigned SETTLE_CYCLES   = 4;
    localparam int unsigned LED_SAMPLES     = 16;
    localparam int unsigned ACK_LIMIT       = RESET_HOLD_CYCLES + 8;
    localparam int unsigned ROW_COUNT       = 13;
    localparam int unsigned WATCHDOG_CYCLES = ROW_COUNT * (RESET_HOLD_CYCLES + 40) * 2;

    typedef enum {DC_PULSE, OPT_PULSE, LOCK_DROP, RESYNC, LED_CHECK} op_t;

    typedef struct {
        op_t           op;
        led_mode_t     mode;
        raw_status_t   raw;
        logic          led;
        int unsigned   events;
        event_counts_t counts;
    } row_t;

    // raw bits are pll54_locked pll_hdmi_locked resync force_generate adv_ready
    // counts are running totals of pll54 loss, hdmi loss and resync events
    row_t rows [ROW_COUNT] = '{
        '{LED_CHECK, LED_STATUS,  5'b11001, 1'b0, 0, '{0, 0, 0}},
        '{DC_PULSE,  LED_DC,      5'b11000, 1'b1, 0, '{0, 0, 0}},
        '{OPT_PULSE, LED_OPT,     5'b11000, 1'b1, 0, '{0, 0, 0}},
        '{LOCK_DROP, LED_STATUS,  5'b11000, 1'b1, 3, '{3, 3, 0}},
        '{RESYNC,    LED_STATUS,  5'b11000, 1'b1, 4, '{3, 3, 4}},
        '{LED_CHECK, LED_STATUS,  5'b10000, 1'b1, 0, '{3, 4, 4}},
        '{LED_CHECK, LED_STATUS,  5'b11010, 1'b1, 0, '{3, 4, 4}},
        '{DC_PULSE,  LED_OPT_ALT, 5'b11000, 1'b1, 0, '{3, 4, 4}},
        '{OPT_PULSE, LED_DC,      5'b11000, 1'b1, 0, '{3, 4, 4}},
        '{LOCK_DROP, LED_STATUS,  5'b11000, 1'b1, 2, '{5, 6, 4}},
        '{RESYNC,    LED_STATUS,  5'b11000, 1'b1, 1, '{5, 6, 5}},
        '{LED_CHECK, LED_STATUS,  5'b10001, 1'b1, 0, '{5, 7, 5}},
        '{LED_CHECK, LED_STATUS,  5'b01001, 1'b0, 0, '{6, 7, 5}}
    };

    logic          control_clock = 1'b0;
    logic          reset_dc;
    host_ctrl_t    host;
    host_ack_t     host_ack;
    raw_status_t   raw_status;
    logic          dc_nreset;
    logic          opt_nreset;
    logic          status_led;
    event_counts_t counts;

    led_count_t  cycle_count;
    logic        prev_dc;
    logic        prev_opt;
    int unsigned checks = 0;
    int unsigned errors = 0;

    dcx_control_top u_dut (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .host          (host),
        .host_ack      (host_ack),
        .raw_status    (raw_status),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .status_led    (status_led),
        .counts        (counts)
    );

    always #5 control_clock = ~control_clock;

    // own copy of the led counter for the blink phase
    always @(posedge control_clock) begin
        if (reset_dc) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_that(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Fail at %0t ns: %s", $time, what);
        end
    endtask

    function automatic int unsigned random_gap();
        return 1 + ($urandom % GAP_MAX);
    endfunction

    function automatic logic nreset_of(input logic opt);
        return opt ? opt_nreset : dc_nreset;
    endfunction

    function automatic logic ack_of(input logic opt);
        return opt ? host_ack.opt_reset_ack : host_ack.dc_reset_ack;
    endfunction

    task automatic set_req(input logic opt, input logic value);
        if (opt) begin
            host.opt_reset_req = value;
        end else begin
            host.dc_reset_req = value;
        end
    endtask

    // one cycle of a pulse
    // led lags the reset lines by one edge
    task automatic next_cycle(input logic opt, input led_mode_t mode);
        @(negedge control_clock);
        check_that(nreset_of(!opt) && !ack_of(!opt), "other channel left its idle state");
        if (mode == LED_DC) begin
            check_that(status_led == prev_dc, "led does not follow dc_nreset");
        end else if (mode == LED_OPT || mode == LED_OPT_ALT) begin
            check_that(status_led == prev_opt, "led does not follow opt_nreset");
        end
        prev_dc  = dc_nreset;
        prev_opt = opt_nreset;
    endtask

    task automatic run_pulse(input logic opt, input led_mode_t mode);
        int unsigned low_cycles;
        int unsigned hold_gap;
        low_cycles = 0;
        hold_gap   = random_gap();
        prev_dc    = dc_nreset;
        prev_opt   = opt_nreset;
        check_that(nreset_of(opt) && !ack_of(opt), "channel not idle before request");
        set_req(opt, 1'b1);
        next_cycle(opt, mode);
        check_that(!nreset_of(opt), "nreset not low one cycle after req");
        while (!ack_of(opt) && low_cycles <= ACK_LIMIT) begin
            check_that(!nreset_of(opt), "nreset released before ack");
            low_cycles++;
            next_cycle(opt, mode);
        end
        assert (ack_of(opt)) else begin
            errors++;
            $display("ack did not rise within %0d cycles at %0t ns", ACK_LIMIT, $time);
        end
        check_that(low_cycles == RESET_HOLD_CYCLES,
                   $sformatf("nreset low for %0d cycles, expected %0d",
                             low_cycles, RESET_HOLD_CYCLES));
        check_that(nreset_of(opt), "nreset not released together with ack");
        repeat (hold_gap) begin
            next_cycle(opt, mode);
            check_that(ack_of(opt) && nreset_of(opt), "ack dropped while req high");
        end
        set_req(opt, 1'b0);
        next_cycle(opt, mode);
        check_that(!ack_of(opt), "ack not low one cycle after req drop");
        repeat (SETTLE_CYCLES) next_cycle(opt, mode);
    endtask

    task automatic drop_locks(input raw_status_t base, input int unsigned n);
        repeat (n) begin
            raw_status = base;
            raw_status.pll54_locked = 1'b0;
            repeat (random_gap()) @(negedge control_clock);
            raw_status = base;
            repeat (random_gap()) @(negedge control_clock);
            raw_status.pll_hdmi_locked = 1'b0;
            repeat (random_gap()) @(negedge control_clock);
            raw_status = base;
            repeat (random_gap()) @(negedge control_clock);
        end
    endtask

    // a long high phase still counts as one event
    task automatic pulse_resync(input raw_status_t base, input int unsigned n);
        repeat (n) begin
            raw_status = base;
            raw_status.resync = 1'b1;
            repeat (random_gap() + 10) @(negedge control_clock);
            raw_status = base;
            repeat (random_gap()) @(negedge control_clock);
        end
    endtask

    task automatic check_led(input row_t row, input int idx);
        led_count_t shown;
        logic       gated;
        gated = row.raw.pll_hdmi_locked && !row.raw.resync && row.raw.force_generate;
        repeat (LED_SAMPLES) begin
            @(negedge control_clock);
            // led reflects the count before the last edge
            shown = cycle_count - 1'b1;
            if (!(gated && shown[BLINK_BIT])) begin
                check_that(status_led == row.led,
                           $sformatf("row %0d led %b, expected %b", idx, status_led, row.led));
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin : main
        int unsigned props_failed;
        host       = '0;
        raw_status = 5'b11000;
        reset_dc   = 1'b1;
        void'($urandom(SEED));
        repeat (3) @(negedge control_clock);
        reset_dc = 1'b0;
        repeat (SETTLE_CYCLES) @(negedge control_clock);

        for (int i = 0; i < ROW_COUNT; i++) begin
            host.led_mode = rows[i].mode;
            raw_status    = rows[i].raw;
            repeat (random_gap() + SETTLE_CYCLES) @(negedge control_clock);
            case (rows[i].op)
                DC_PULSE:  run_pulse(1'b0, rows[i].mode);
                OPT_PULSE: run_pulse(1'b1, rows[i].mode);
                LOCK_DROP: drop_locks(rows[i].raw, rows[i].events);
                RESYNC:    pulse_resync(rows[i].raw, rows[i].events);
                LED_CHECK: check_led(rows[i], i);
            endcase
            repeat (SETTLE_CYCLES) @(negedge control_clock);
            check_that(counts == rows[i].counts,
                       $sformatf("row %0d counts %0d/%0d/%0d, expected %0d/%0d/%0d", i,
                                 counts.pll54_lockloss, counts.pll_hdmi_lockloss,
                                 counts.resync_events, rows[i].counts.pll54_lockloss,
                                 rows[i].counts.pll_hdmi_lockloss,
                                 rows[i].counts.resync_events));
        end

        // opt channel parked in its ack phase
        host.led_mode = LED_DC;
        set_req(1'b1, 1'b1);
        repeat (RESET_HOLD_CYCLES + 2) @(negedge control_clock);
        check_that(host_ack.opt_reset_ack && opt_nreset, "opt ack not high before reset_dc");

        // reset_dc in the middle of a dc hold
        set_req(1'b0, 1'b1);
        repeat (RESET_HOLD_CYCLES / 2) @(negedge control_clock);
        check_that(!dc_nreset, "dc_nreset not low during hold");
        reset_dc = 1'b1;
        repeat (3) @(negedge control_clock);
        reset_dc = 1'b0;
        @(negedge control_clock);
        check_that(counts == '0, "counts not cleared by reset_dc");
        check_that(dc_nreset && opt_nreset, "reset lines not released after reset_dc");
        check_that(host_ack == '0, "acks not low after reset_dc");
        repeat (SETTLE_CYCLES) begin
            @(negedge control_clock);
            check_that(dc_nreset && opt_nreset && host_ack == '0,
                       "stale req started a pulse");
        end
        set_req(1'b0, 1'b0);
        set_req(1'b1, 1'b0);
        repeat (SETTLE_CYCLES) @(negedge control_clock);
        run_pulse(1'b0, LED_DC);

        props_failed = u_dut.u_dc_reset.u_props.violations
                     + u_dut.u_opt_reset.u_props.violations;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, props_failed);
        if (errors == 0 && props_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge control_clock);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/dcx_control_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcx_control_props
    import dcx_ctrl_pkg::*;
(
    input wire          control_clock,
    input wire          reset_dc,
    input wire          req,
    input wire          ack,
    input wire          nreset,
    input wire          armed,
    input reset_state_t state
);

    int unsigned violations = 0;

    // accepted request pulls the line on the next edge
    start_low: assert property (@(posedge control_clock) disable iff (reset_dc)
        (state == RST_IDLE && req && armed) |=> !nreset)
    else begin
        violations++;
        $error("nreset not low one cycle after an accepted request");
    end

    ack_released: assert property (@(posedge control_clock) disable iff (reset_dc)
        ack |-> nreset)
    else begin
        violations++;
        $error("ack high while nreset is still low");
    end

    // ack only drops after the host let go of req
    ack_fall: assert property (@(posedge control_clock) disable iff (reset_dc)
        $fell(ack) |-> !$past(req))
    else begin
        violations++;
        $error("ack fell while req was still high");
    end

endmodule

bind reset_sequencer dcx_control_props u_props (
    .control_clock (control_clock),
    .reset_dc      (reset_dc),
    .req           (req),
    .ack           (ack),
    .nreset        (nreset),
    .armed         (armed),
    .state         (state)
);

`default_nettype wire

// ==== design/dcx_control_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcx_control_top import dcx_ctrl_pkg::*; (
    input  wire           control_clock,
    input  wire           reset_dc,

    // host side
    input  host_ctrl_t    host,
    output host_ack_t     host_ack,

    input  raw_status_t   raw_status,

    // console lines, 1 means released
    output logic          dc_nreset,
    output logic          opt_nreset,
    output logic          status_led,

    output event_counts_t counts
);

    logic         dc_ack;
    logic         opt_ack;
    sync_status_t sync_status;

    assign host_ack = '{dc_reset_ack: dc_ack, opt_reset_ack: opt_ack};

    //////////////////////////////
    // reset channels
    //////////////////////////////

    reset_sequencer u_dc_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .req           (host.dc_reset_req),
        .ack           (dc_ack),
        .nreset        (dc_nreset)
    );

    // optional board
    reset_sequencer u_opt_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .req           (host.opt_reset_req),
        .ack           (opt_ack),
        .nreset        (opt_nreset)
    );

    //////////////////////////////
    // status and monitoring
    //////////////////////////////

    lockloss_monitor u_monitor (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .raw           (raw_status),
        .status        (sync_status),
        .counts        (counts)
    );

    status_led u_led (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .mode          (host.led_mode),
        .status        (sync_status),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .led           (status_led)
    );

endmodule

`default_nettype wire

// ==== design/lockloss_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lockloss_monitor import dcx_ctrl_pkg::*; (
    input  wire           control_clock,
    input  wire           reset_dc,
    input  raw_status_t   raw,
    output sync_status_t  status,
    output event_counts_t counts
);

    sync_status_t sync_1;
    sync_status_t status_prev;

    logic pll54_fall;
    logic pll_hdmi_fall;
    logic resync_rise;

    //////////////////////////////
    // two-flop synchronizers
    //////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_1 <= '0;
            status <= '0;
        end else begin
            sync_1 <= sync_status_t'(raw);
            status <= sync_1;
        end
    end

    //////////////////////////////
    // edges
    //////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            status_prev <= '0;
        end else begin
            status_prev <= status;
        end
    end

    // lock loss is the falling edge
    assign pll54_fall    = status_prev.pll54_locked    & ~status.pll54_locked;
    assign pll_hdmi_fall = status_prev.pll_hdmi_locked & ~status.pll_hdmi_locked;
    assign resync_rise   = ~status_prev.resync         &  status.resync;

    // counters wrap
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            counts <= '0;
        end else begin
            if (pll54_fall) begin
                counts.pll54_lockloss <= counts.pll54_lockloss + 1'b1;
            end
            if (pll_hdmi_fall) begin
                counts.pll_hdmi_lockloss <= counts.pll_hdmi_lockloss + 1'b1;
            end
            if (resync_rise) begin
                counts.resync_events <= counts.resync_events + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/status_led.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_led import dcx_ctrl_pkg::*; (
    input  wire          control_clock,
    input  wire          reset_dc,
    input  led_mode_t    mode,
    input  sync_status_t status,
    input  wire          dc_nreset,
    input  wire          opt_nreset,
    output logic         led
);

    led_count_t led_count;
    logic       glow_slow;
    logic       glow_fast;
    logic       blink_on;
    logic       led_next;

    // 4-bit pwm against a triangle
    // the ramp sits just below the direction bit at pos + 1
    function automatic logic glow(input led_count_t cnt, input int unsigned pos);
        logic [3:0] ramp;
        logic [3:0] level;
        ramp  = 4'(cnt >> (pos - 3));
        level = cnt[pos + 1] ? ramp : ~ramp;
        return (cnt[3:0] < level);
    endfunction

    //////////////////////////////
    // pattern sources
    //////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_count <= '0;
        end else begin
            led_count <= led_count + 1'b1;
        end
    end

    assign glow_slow = glow(led_count, GLOW_SLOW_BIT);
    assign glow_fast = glow(led_count, GLOW_FAST_BIT);
    assign blink_on  = led_count[BLINK_BIT];

    //////////////////////////////
    // source select
    //////////////////////////////

    always_comb begin
        led_next = 1'b1;
        unique case (mode)
            LED_DC: begin
                led_next = dc_nreset;
            end
            LED_OPT, LED_OPT_ALT: begin
                led_next = opt_nreset;
            end
            default: begin
                // status display, highest priority first
                if (!status.pll_hdmi_locked) begin
                    led_next = 1'b1;
                end else if (status.resync) begin
                    led_next = ~glow_fast;
                end else if (status.force_generate) begin
                    led_next = blink_on ? ~glow_fast : 1'b1;
                end else if (status.adv_ready) begin
                    led_next = 1'b0;
                end else begin
                    led_next = ~glow_slow;
                end
            end
        endcase
    end

    // led line is active low, so 1 is dark
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led <= 1'b1;
        end else begin
            led <= led_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer import dcx_ctrl_pkg::*; (
    input  wire  control_clock,
    input  wire  reset_dc,
    input  logic req,
    output logic ack,
    output logic nreset
);

    reset_state_t state;
    reset_state_t state_next;

    // req has been low since the last pulse started
    logic armed;
    logic start;
    logic hold_done;

    //////////////////////////////
    // hold timer
    //////////////////////////////

    assign start = (state == RST_IDLE) && req && armed;

    hold_timer u_timer (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .load          (start),
        .done          (hold_done)
    );

    //////////////////////////////
    // handshake FSM
    //////////////////////////////

    always_comb begin
        state_next = state;
        unique case (state)
            RST_IDLE: begin
                if (start) begin
                    state_next = RST_HOLD;
                end
            end
            RST_HOLD: begin
                // release and acknowledge together
                if (hold_done) begin
                    state_next = RST_ACK;
                end
            end
            RST_ACK: begin
                if (!req) begin
                    state_next = RST_IDLE;
                end
            end
            default: begin
                state_next = RST_IDLE;
            end
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            state <= RST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // a req left high across reset or a pulse must drop first
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            armed <= 1'b0;
        end else if (start) begin
            armed <= 1'b0;
        end else if (!req) begin
            armed <= 1'b1;
        end
    end

    // outputs registered from the next state
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            nreset <= 1'b1;
            ack    <= 1'b0;
        end else begin
            nreset <= (state_next != RST_HOLD);
            ack    <= (state_next == RST_ACK);
        end
    end

endmodule

`default_nettype wire

// ==== design/hold_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hold_timer import dcx_ctrl_pkg::*; (
    input  wire  control_clock,
    input  wire  reset_dc,
    input  logic load,
    output logic done
);

    // last value before expiry, count runs down to zero
    localparam hold_count_t HOLD_LAST = hold_count_t'(RESET_HOLD_CYCLES - 1);

    hold_count_t count;

    // load takes effect on the edge it is sampled on,
    // so zero is reached RESET_HOLD_CYCLES - 1 edges later
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
        end else if (load) begin
            count <= HOLD_LAST;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // expired, stays up until the next load
    assign done = (count == '0);

endmodule

`default_nettype wire

// ==== design/dcx_ctrl_pkg.sv ====
`default_nettype none

package dcx_ctrl_pkg;

    //////////////////////////////
    // timing and widths
    //////////////////////////////

    // reset line hold, short for simulation
    localparam int unsigned RESET_HOLD_CYCLES = 64;
    localparam int unsigned HOLD_WIDTH        = 7;

    // led counter taps
    localparam int unsigned GLOW_SLOW_BIT     = 12;
    localparam int unsigned GLOW_FAST_BIT     = 8;
    localparam int unsigned BLINK_BIT         = 14;
    localparam int unsigned LED_COUNT_WIDTH   = 16;

    localparam int unsigned EVENT_WIDTH       = 32;

    typedef logic [HOLD_WIDTH-1:0]      hold_count_t;
    typedef logic [EVENT_WIDTH-1:0]     event_count_t;
    typedef logic [LED_COUNT_WIDTH-1:0] led_count_t;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // LED_OPT_ALT is treated as LED_OPT
    typedef enum logic [1:0] {
        LED_STATUS  = 2'd0,
        LED_OPT     = 2'd1,
        LED_DC      = 2'd2,
        LED_OPT_ALT = 2'd3
    } led_mode_t;

    typedef enum logic [1:0] {
        RST_IDLE = 2'd0,
        RST_HOLD = 2'd1,
        RST_ACK  = 2'd2
    } reset_state_t;

    //////////////////////////////
    // bundles
    //////////////////////////////

    typedef struct packed {
        logic      dc_reset_req;
        logic      opt_reset_req;
        led_mode_t led_mode;
    } host_ctrl_t;

    typedef struct packed {
        logic dc_reset_ack;
        logic opt_reset_ack;
    } host_ack_t;

    // straight from the pins, asynchronous
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
        logic adv_ready;
    } raw_status_t;

    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
        logic adv_ready;
    } sync_status_t;

    typedef struct packed {
        event_count_t pll54_lockloss;
        event_count_t pll_hdmi_lockloss;
        event_count_t resync_events;
    } event_counts_t;

endpackage

`default_nettype wire
